/* design/cpu_macros.svh */
// Core sizing constants; both memory depths must be powers of two so that addresses wrap cleanly
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Data path and instruction width
`define CPU_XLEN 16

// Architectural registers, register 0 is an ordinary register
`define CPU_NREGS 8

// Instruction memory depth in words
`define CPU_IMEM_DEPTH 256

// Data memory depth in words
`define CPU_DMEM_DEPTH 256

// Address widths follow from the depths
`define CPU_IMEM_AW $clog2(`CPU_IMEM_DEPTH)
`define CPU_DMEM_AW $clog2(`CPU_DMEM_DEPTH)

`endif

/* design/isaPkg.sv */
// ISA types for the reduced 16-bit set; any opcode outside the ten listed is treated as illegal
`default_nettype none
`include "cpu_macros.svh"

package isaPkg;

  typedef logic [`CPU_XLEN-1:0] wordT;
  typedef logic [$clog2(`CPU_NREGS)-1:0] regIdxT;

  // Opcode sits in the top five bits
  typedef enum logic [4:0] {
    opNop  = 5'd0,
    opAdd  = 5'd1,
    opSub  = 5'd2,
    opAnd  = 5'd3,
    opXor  = 5'd4,
    opAddi = 5'd5,
    opLd   = 5'd6,
    opSt   = 5'd7,
    opBeqz = 5'd8,
    opHalt = 5'd9
  } opcodeT;

  // Pass forwards operand A, BEQZ tests it against zero
  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluXor,
    aluPass
  } aluOpT;

  // Field positions
  localparam int opMsb  = 15;
  localparam int opLsb  = 11;
  localparam int rdMsb  = 10;
  localparam int rdLsb  = 8;
  localparam int rsMsb  = 7;
  localparam int rsLsb  = 5;
  localparam int rtMsb  = 4;
  localparam int rtLsb  = 2;
  // I form immediate, signed
  localparam int immMsb = 4;
  localparam int immLsb = 0;
  // BEQZ offset, signed, register in the rd slot
  localparam int offMsb = 7;
  localparam int offLsb = 0;

  // Registers read by an instruction
  typedef struct packed {
    logic   useA;
    regIdxT a;
    logic   useB;
    regIdxT b;
  } srcRegsT;

  // Shared by decode and the load-use check
  function automatic srcRegsT srcRegsOf(input wordT instr);
    srcRegsT s;
    s.useA = 1'b0;
    s.useB = 1'b0;
    s.a = instr[rsMsb:rsLsb];
    s.b = instr[rtMsb:rtLsb];
    case (opcodeT'(instr[opMsb:opLsb]))
      opAdd, opSub, opAnd, opXor: begin
        s.useA = 1'b1;
        s.useB = 1'b1;
      end
      opAddi, opLd: begin
        s.useA = 1'b1;
      end
      // Store data comes from rd
      opSt: begin
        s.useA = 1'b1;
        s.useB = 1'b1;
        s.b = instr[rdMsb:rdLsb];
      end
      opBeqz: begin
        s.useA = 1'b1;
        s.a = instr[rdMsb:rdLsb];
      end
      default: begin
      end
    endcase
    return s;
  endfunction

endpackage

`default_nettype wire

/* design/pipePkg.sv */
// Pipeline payloads; an all-zero payload is a bubble, so valid must stay meaningful at zero
`default_nettype none
`include "cpu_macros.svh"

package pipePkg;
  import isaPkg::*;

  typedef logic [`CPU_DMEM_AW-1:0] dAddrT;

  // Operand source selects
  localparam logic [1:0] fwdReg   = 2'd0;
  localparam logic [1:0] fwdExMem = 2'd1;
  localparam logic [1:0] fwdMemWb = 2'd2;

  // Illegal rides with halt so the error shows at retirement
  typedef struct packed {
    logic  regWrite;
    logic  memRead;
    logic  memWrite;
    logic  aluSrcImm;
    logic  branch;
    logic  halt;
    logic  illegal;
    aluOpT aluOp;
  } ctrlT;

  typedef struct packed {
    logic valid;
    wordT pc;
    wordT instr;
  } ifIdT;

  typedef struct packed {
    logic   valid;
    wordT   pc;
    ctrlT   ctrl;
    regIdxT srcA;
    regIdxT srcB;
    wordT   opA;
    wordT   opB;
    regIdxT dest;
    wordT   imm;
  } idExT;

  typedef struct packed {
    logic   valid;
    wordT   pc;
    ctrlT   ctrl;
    regIdxT dest;
    wordT   aluResult;
    wordT   storeData;
  } exMemT;

  // Result holds the store data for ST
  typedef struct packed {
    logic   valid;
    wordT   pc;
    logic   regWrite;
    logic   halt;
    logic   illegal;
    logic   store;
    dAddrT  storeAddr;
    regIdxT dest;
    wordT   result;
  } memWbT;

  typedef struct packed {
    wordT   pc;
    logic   regWrite;
    regIdxT dest;
    wordT   data;
    logic   store;
    dAddrT  storeAddr;
    wordT   storeData;
  } retireT;

endpackage

`default_nettype wire

/* design/pipeStage.sv */
// Generic stage latch; flush wins over hold, and reset or flush leaves an all-zero bubble
`timescale 1ns/1ps
`default_nettype none

module pipeStage #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    hold,
  input  logic    flush,
  input  payloadT d,
  output payloadT q
);

  // Zero payload has valid low
  always_ff @(posedge clk) begin
    if (!rstN || flush) begin
      q <= '0;
    end else if (!hold) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

/* design/fetchUnit.sv */
// Fetch with word-addressed PC; program words are taken only while rstN is low, PC wraps at depth
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module fetchUnit
  import isaPkg::*, pipePkg::*;
(
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    progWe,
  input  logic [`CPU_IMEM_AW-1:0] progAddr,
  input  wordT                    progData,
  input  logic                    stall,
  input  logic                    redirect,
  input  wordT                    redirectPc,
  input  logic                    stopFetch,
  output ifIdT                    ifOut
);

  wordT pc;
  wordT imem [`CPU_IMEM_DEPTH];

  // Program load port, live only in reset
  always_ff @(posedge clk) begin
    if (!rstN && progWe) begin
      imem[progAddr] <= progData;
    end
  end

  // Redirect beats stall, a stopped fetch parks the PC
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= redirectPc;
    end else if (!stall && !stopFetch) begin
      pc <= pc + `CPU_XLEN'(1);
    end
  end

  // Bubble once a HALT has been seen
  always_comb begin
    ifOut.valid = !stopFetch;
    ifOut.pc = pc;
    ifOut.instr = imem[pc[`CPU_IMEM_AW-1:0]];
  end

endmodule

`default_nettype wire

/* design/decodeUnit.sv */
// Decode and register file; write-through covers a read of the register retiring this cycle
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module decodeUnit
  import isaPkg::*, pipePkg::*;
(
  input  logic  clk,
  input  logic  rstN,
  input  ifIdT  ifIn,
  input  memWbT wbIn,
  output idExT  idOut,
  output logic  haltSeen
);

  wordT    regs [`CPU_NREGS];
  opcodeT  opcode;
  ctrlT    ctrl;
  srcRegsT src;
  logic    wbWrite;
  wordT    readA;
  wordT    readB;

  assign opcode = opcodeT'(ifIn.instr[opMsb:opLsb]);
  assign src = srcRegsOf(ifIn.instr);
  assign wbWrite = wbIn.valid && wbIn.regWrite;

  // Register file, cleared at reset
  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wbWrite) begin
      regs[wbIn.dest] <= wbIn.result;
    end
  end

  // Same-cycle writeback goes first
  assign readA = (wbWrite && wbIn.dest == src.a) ? wbIn.result : regs[src.a];
  assign readB = (wbWrite && wbIn.dest == src.b) ? wbIn.result : regs[src.b];

  // Control decode
  always_comb begin
    ctrl = '0;
    ctrl.aluOp = aluAdd;
    case (opcode)
      opNop: begin
      end
      opAdd: begin
        ctrl.regWrite = 1'b1;
      end
      opSub: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluOp = aluSub;
      end
      opAnd: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluOp = aluAnd;
      end
      opXor: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluOp = aluXor;
      end
      opAddi: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrcImm = 1'b1;
      end
      // Base plus offset for both memory ops
      opLd: begin
        ctrl.regWrite = 1'b1;
        ctrl.memRead = 1'b1;
        ctrl.aluSrcImm = 1'b1;
      end
      opSt: begin
        ctrl.memWrite = 1'b1;
        ctrl.aluSrcImm = 1'b1;
      end
      opBeqz: begin
        ctrl.branch = 1'b1;
        ctrl.aluOp = aluPass;
      end
      opHalt: begin
        ctrl.halt = 1'b1;
      end
      // Unknown opcode stops the core and flags an error
      default: begin
        ctrl.halt = 1'b1;
        ctrl.illegal = 1'b1;
      end
    endcase
  end

  always_comb begin
    idOut.valid = ifIn.valid;
    idOut.pc = ifIn.pc;
    idOut.ctrl = ctrl;
    idOut.srcA = src.a;
    idOut.srcB = src.b;
    idOut.opA = readA;
    idOut.opB = readB;
    idOut.dest = ifIn.instr[rdMsb:rdLsb];
    // BEQZ has the wider offset
    if (opcode == opBeqz) begin
      idOut.imm = {{(`CPU_XLEN-8){ifIn.instr[offMsb]}}, ifIn.instr[offMsb:offLsb]};
    end else begin
      idOut.imm = {{(`CPU_XLEN-5){ifIn.instr[immMsb]}}, ifIn.instr[immMsb:immLsb]};
    end
  end

  // Tells the top to stop fetching
  assign haltSeen = ifIn.valid && ctrl.halt;

endmodule

`default_nettype wire

/* design/hazardUnit.sv */
// Load-use stall and forward selects; a load result is never forwarded from EX/MEM
`timescale 1ns/1ps
`default_nettype none

module hazardUnit
  import isaPkg::*, pipePkg::*;
(
  input  ifIdT        ifIn,
  input  idExT        idEx,
  input  exMemT       exMem,
  input  memWbT       memWb,
  output logic        stall,
  output logic [1:0]  fwdA,
  output logic [1:0]  fwdB
);

  srcRegsT src;
  logic    loadInEx;
  logic    exMemWrites;
  logic    memWbWrites;

  assign src = srcRegsOf(ifIn.instr);

  // Load in execute feeding the instruction in decode
  assign loadInEx = idEx.valid && idEx.ctrl.memRead && idEx.ctrl.regWrite;
  assign stall = ifIn.valid && loadInEx &&
                 ((src.useA && src.a == idEx.dest) || (src.useB && src.b == idEx.dest));

  assign exMemWrites = exMem.valid && exMem.ctrl.regWrite;
  assign memWbWrites = memWb.valid && memWb.regWrite;

  // Newer EX/MEM result wins over MEM/WB
  function automatic logic [1:0] pickFwd(input regIdxT srcReg);
    if (exMemWrites && exMem.dest == srcReg) begin
      return fwdExMem;
    end else if (memWbWrites && memWb.dest == srcReg) begin
      return fwdMemWb;
    end
    return fwdReg;
  endfunction

  assign fwdA = pickFwd(idEx.srcA);
  assign fwdB = pickFwd(idEx.srcB);

endmodule

`default_nettype wire

/* design/executeUnit.sv */
// Execute stage; BEQZ resolves here and its target is PC plus one plus the signed offset
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module executeUnit
  import isaPkg::*, pipePkg::*;
(
  input  idExT                 exIn,
  input  logic [1:0]           fwdA,
  input  logic [1:0]           fwdB,
  input  logic [`CPU_XLEN-1:0] exMemFwd,
  input  logic [`CPU_XLEN-1:0] memWbFwd,
  output exMemT                exOut,
  output logic                 redirect,
  output logic [`CPU_XLEN-1:0] redirectPc
);

  wordT opA;
  wordT opB;
  wordT aluB;
  wordT aluResult;

  // Forwarding muxes
  always_comb begin
    case (fwdA)
      fwdExMem: opA = exMemFwd;
      fwdMemWb: opA = memWbFwd;
      default:  opA = exIn.opA;
    endcase
    case (fwdB)
      fwdExMem: opB = exMemFwd;
      fwdMemWb: opB = memWbFwd;
      default:  opB = exIn.opB;
    endcase
  end

  // Immediate for ADDI, LD and ST
  assign aluB = exIn.ctrl.aluSrcImm ? exIn.imm : opB;

  always_comb begin
    case (exIn.ctrl.aluOp)
      aluAdd:  aluResult = opA + aluB;
      aluSub:  aluResult = opA - aluB;
      aluAnd:  aluResult = opA & aluB;
      aluXor:  aluResult = opA ^ aluB;
      aluPass: aluResult = opA;
      default: aluResult = '0;
    endcase
  end

  // Taken only on a zero operand
  assign redirect = exIn.valid && exIn.ctrl.branch && (opA == '0);
  assign redirectPc = exIn.pc + `CPU_XLEN'(1) + exIn.imm;

  always_comb begin
    exOut.valid = exIn.valid;
    exOut.pc = exIn.pc;
    exOut.ctrl = exIn.ctrl;
    exOut.dest = exIn.dest;
    exOut.aluResult = aluResult;
    // Store data after forwarding
    exOut.storeData = opB;
  end

endmodule

`default_nettype wire

/* design/memoryUnit.sv */
// Data memory cleared by reset; addresses wrap modulo the depth, loads read combinationally
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module memoryUnit
  import isaPkg::*, pipePkg::*;
(
  input  logic  clk,
  input  logic  rstN,
  input  exMemT memIn,
  output memWbT memOut
);

  wordT  dmem [`CPU_DMEM_DEPTH];
  dAddrT addr;
  wordT  loadData;

  // Low bits of the effective address
  assign addr = memIn.aluResult[`CPU_DMEM_AW-1:0];
  assign loadData = dmem[addr];

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < `CPU_DMEM_DEPTH; i++) begin
        dmem[i] <= '0;
      end
    end else if (memIn.valid && memIn.ctrl.memWrite) begin
      dmem[addr] <= memIn.storeData;
    end
  end

  always_comb begin
    memOut.valid = memIn.valid;
    memOut.pc = memIn.pc;
    memOut.regWrite = memIn.ctrl.regWrite;
    memOut.halt = memIn.ctrl.halt;
    memOut.illegal = memIn.ctrl.illegal;
    memOut.store = memIn.ctrl.memWrite;
    memOut.storeAddr = addr;
    memOut.dest = memIn.dest;
    // Store record reuses the result field
    if (memIn.ctrl.memRead) begin
      memOut.result = loadData;
    end else if (memIn.ctrl.memWrite) begin
      memOut.result = memIn.storeData;
    end else begin
      memOut.result = memIn.aluResult;
    end
  end

endmodule

`default_nettype wire

/* design/proc.sv */
// Five-stage core top; load the program only during reset, halted and err stay set until reset
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module proc
  import isaPkg::*, pipePkg::*;
(
  input  logic                    clk,
  input  logic                    rstN,
  input  logic                    progWe,
  input  logic [`CPU_IMEM_AW-1:0] progAddr,
  input  wordT                    progData,
  output logic                    retireValid,
  output retireT                  retire,
  output logic                    halted,
  output logic                    err
);

  ifIdT  fetchOut;
  ifIdT  ifIdQ;
  idExT  decodeOut;
  idExT  idExQ;
  exMemT execOut;
  exMemT exMemQ;
  memWbT memOut;
  memWbT memWbQ;

  logic       stall;
  logic       redirect;
  wordT       redirectPc;
  logic       haltSeen;
  logic       fetchStopped;
  logic       stopFetch;
  logic [1:0] fwdA;
  logic [1:0] fwdB;

  // A HALT squashed by a taken branch does not stop fetch
  assign stopFetch = fetchStopped || (haltSeen && !redirect);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      fetchStopped <= 1'b0;
    end else if (haltSeen && !redirect) begin
      fetchStopped <= 1'b1;
    end
  end

  fetchUnit fetch (
    .clk, .rstN, .progWe, .progAddr, .progData,
    .stall, .redirect, .redirectPc, .stopFetch,
    .ifOut(fetchOut)
  );

  // Stall holds IF/ID, branch flushes it
  pipeStage #(.payloadT(ifIdT)) ifId (
    .clk, .rstN, .hold(stall), .flush(redirect), .d(fetchOut), .q(ifIdQ)
  );

  decodeUnit decode (
    .clk, .rstN, .ifIn(ifIdQ), .wbIn(memWbQ), .idOut(decodeOut), .haltSeen
  );

  hazardUnit hazard (
    .ifIn(ifIdQ), .idEx(idExQ), .exMem(exMemQ), .memWb(memWbQ),
    .stall, .fwdA, .fwdB
  );

  // Bubble on stall or branch
  pipeStage #(.payloadT(idExT)) idEx (
    .clk, .rstN, .hold(1'b0), .flush(redirect || stall), .d(decodeOut), .q(idExQ)
  );

  executeUnit execute (
    .exIn(idExQ), .fwdA, .fwdB,
    .exMemFwd(exMemQ.aluResult), .memWbFwd(memWbQ.result),
    .exOut(execOut), .redirect, .redirectPc
  );

  pipeStage #(.payloadT(exMemT)) exMem (
    .clk, .rstN, .hold(1'b0), .flush(1'b0), .d(execOut), .q(exMemQ)
  );

  memoryUnit memory (
    .clk, .rstN, .memIn(exMemQ), .memOut
  );

  pipeStage #(.payloadT(memWbT)) memWb (
    .clk, .rstN, .hold(1'b0), .flush(1'b0), .d(memOut), .q(memWbQ)
  );

  // Sticky status, set the edge after HALT retires
  always_ff @(posedge clk) begin
    if (!rstN) begin
      halted <= 1'b0;
      err <= 1'b0;
    end else if (memWbQ.valid && memWbQ.halt) begin
      halted <= 1'b1;
      err <= err || memWbQ.illegal;
    end
  end

  // Trace port straight from MEM/WB
  assign retireValid = memWbQ.valid;

  always_comb begin
    retire.pc = memWbQ.pc;
    retire.regWrite = memWbQ.regWrite;
    retire.dest = memWbQ.dest;
    retire.data = memWbQ.result;
    retire.store = memWbQ.store;
    retire.storeAddr = memWbQ.storeAddr;
    retire.storeData = memWbQ.store ? memWbQ.result : '0;
  end

endmodule

`default_nettype wire

/* test/proc_sva.sv */
// Pipeline control checks bound into the core top; all of them are disabled while rstN is low
`timescale 1ns/1ps
`default_nettype none

module proc_sva (
  input logic clk,
  input logic rstN,
  input logic retireValid,
  input logic halted,
  input logic err,
  input logic stall,
  input logic redirect
);

  // Count of failed properties
  int failCount = 0;

  // Halted only clears through reset
  haltedSticky: assert property (@(posedge clk) disable iff (!rstN) halted |=> halted)
    else begin
      failCount++;
      $error("halted dropped without a reset");
    end

  // Nothing retires once the core has stopped
  noRetireWhileHalted: assert property (@(posedge clk) disable iff (!rstN)
    halted |-> !retireValid)
    else begin
      failCount++;
      $error("instruction retired while halted");
    end

  // Error comes with the illegal HALT, on the edge that stops the core
  errRisesWithHalted: assert property (@(posedge clk) disable iff (!rstN)
    $rose(err) |-> $rose(halted))
    else begin
      failCount++;
      $error("err rose without halted rising with it");
    end

  // Load-use costs exactly one bubble
  oneBubbleStall: assert property (@(posedge clk) disable iff (!rstN) stall |=> !stall)
    else begin
      failCount++;
      $error("stall held for two cycles");
    end

  // After a taken branch the ID/EX slot is a bubble
  singleRedirect: assert property (@(posedge clk) disable iff (!rstN)
    redirect |=> !redirect)
    else begin
      failCount++;
      $error("redirect on two cycles in a row");
    end

  // A load and a branch cannot share ID/EX
  noStallOnRedirect: assert property (@(posedge clk) disable iff (!rstN)
    !(stall && redirect))
    else begin
      failCount++;
      $error("stall and redirect in the same cycle");
    end

endmodule

bind proc proc_sva sva (
  .clk(clk),
  .rstN(rstN),
  .retireValid(retireValid),
  .halted(halted),
  .err(err),
  .stall(stall),
  .redirect(redirect)
);

`default_nettype wire

/* test/procTb.sv */
// Random-program testbench; each program is loaded while rstN is low, branch offsets forward only
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module procTb
  import isaPkg::*, pipePkg::*;
();

  localparam int clkPeriod = 20;
  localparam int resetCycles = 5;
  localparam int progLen = 121;
  localparam int numRuns = 4;
  localparam int illegalIdx = 60;
  // Worst case three cycles per instruction plus drain
  localparam int runCycles = 3 * progLen + 20;
  localparam int watchdogNs = numRuns * (progLen + resetCycles + runCycles) * clkPeriod;

  logic                    clk;
  logic                    rstN;
  logic                    progWe;
  logic [`CPU_IMEM_AW-1:0] progAddr;
  logic [15:0]             progData;
  logic                    retireValid;
  retireT                  retire;
  logic                    halted;
  logic                    err;

  integer      seed = 32'hdf1f;
  logic [15:0] prog [`CPU_IMEM_DEPTH];
  retireT      expQ [$];
  int          errCount;
  int          svaFails;
  int          checkCount;
  int          retireCount;
  int          modelCount;
  logic        expErr;

  proc u_dut (
    .clk, .rstN, .progWe, .progAddr, .progData,
    .retireValid, .retire, .halted, .err
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  function automatic int randBelow(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Encoders, opcode in the top five bits
  function automatic logic [15:0] encR(input logic [4:0] op, input logic [2:0] rd,
                                       input logic [2:0] rs, input logic [2:0] rt);
    return {op, rd, rs, rt, 2'b00};
  endfunction

  function automatic logic [15:0] encI(input logic [4:0] op, input logic [2:0] rd,
                                       input logic [2:0] rs, input logic [4:0] imm);
    return {op, rd, rs, imm};
  endfunction

  function automatic logic [4:0] randAluOp();
    case (randBelow(4))
      0: return opAdd;
      1: return opSub;
      2: return opAnd;
      default: return opXor;
    endcase
  endfunction

  // Target stays at or before the instruction that ends the program
  function automatic logic [15:0] makeBranch(input int i, input int stopIdx,
                                             input logic [2:0] rd);
    int endIdx;
    int lim;
    endIdx = (i < stopIdx) ? stopIdx : progLen - 1;
    lim = endIdx - i;
    if (lim > 8) begin
      lim = 8;
    end
    return {opBeqz, rd, 8'(randBelow(lim))};
  endfunction

  // Modes: 0 dependency, 1 load/store, 2 branch, 3 illegal opcode
  task automatic genProgram(input int mode);
    int         pick;
    int         span;
    int         stopIdx;
    logic [2:0] rd;
    logic [2:0] rs;
    logic [2:0] rt;
    logic [2:0] base;
    logic [4:0] imm;
    stopIdx = (mode == 3) ? illegalIdx : progLen - 1;
    // Few registers give dense dependencies
    span = (mode == 0 || mode == 2) ? 4 : ((mode == 1) ? 6 : 8);
    for (int i = 0; i < progLen - 1; i++) begin
      pick = randBelow(100);
      rd = 3'(randBelow(span));
      rs = 3'(randBelow(span));
      rt = 3'(randBelow(span));
      imm = 5'(randBelow(32));
      // Base registers 6 and 7 stay zero, so addresses collide
      base = 3'(6 + randBelow(2));
      if (i < 2) begin
        // Opening loads see the cleared data memory
        prog[i] = encI(opLd, rd, rs, imm);
      end else begin
        case (mode)
          0: begin
            if (pick < 70) prog[i] = encR(randAluOp(), rd, rs, rt);
            else if (pick < 88) prog[i] = encI(opAddi, rd, rs, imm);
            else if (pick < 94) prog[i] = encI(opLd, rd, rs, imm);
            else if (pick < 97) prog[i] = encI(opSt, rd, rs, imm);
            else prog[i] = {opNop, 11'd0};
          end
          1: begin
            if (pick < 35) prog[i] = encI(opLd, rd, base, imm);
            else if (pick < 70) prog[i] = encI(opSt, rd, base, imm);
            else if (pick < 90) prog[i] = encI(opAddi, rd, rs, imm);
            else prog[i] = encR(randAluOp(), rd, rs, rt);
          end
          2: begin
            if (pick < 40) prog[i] = makeBranch(i, stopIdx, rd);
            // XOR with itself clears a register for taken branches
            else if (pick < 60) prog[i] = encR(opXor, rd, rs, rs);
            else if (pick < 85) prog[i] = encI(opAddi, rd, rs, imm);
            else if (pick < 95) prog[i] = encR(randAluOp(), rd, rs, rt);
            else prog[i] = {opNop, 11'd0};
          end
          default: begin
            if (pick < 40) prog[i] = encR(randAluOp(), rd, rs, rt);
            else if (pick < 60) prog[i] = encI(opAddi, rd, rs, imm);
            else if (pick < 70) prog[i] = encI(opLd, rd, rs, imm);
            else if (pick < 80) prog[i] = encI(opSt, rd, rs, imm);
            else if (pick < 90) prog[i] = makeBranch(i, stopIdx, rd);
            else prog[i] = {opNop, 11'd0};
          end
        endcase
      end
    end
    prog[progLen - 1] = {opHalt, 11'd0};
    // Opcodes 10 to 31 are unused
    if (mode == 3) begin
      prog[illegalIdx] = {5'(10 + randBelow(22)), 11'(randBelow(2048))};
    end
  endtask

  // Sequential ISA model, fills the expected retire queue
  task automatic runModel();
    logic [15:0]             regs [`CPU_NREGS];
    logic [15:0]             mem [`CPU_DMEM_DEPTH];
    logic [15:0]             instr;
    logic [15:0]             a;
    logic [15:0]             b;
    logic [15:0]             imm;
    logic [15:0]             off;
    logic [`CPU_DMEM_AW-1:0] addr;
    logic [4:0]              op;
    logic [2:0]              rd;
    logic [2:0]              rs;
    logic [2:0]              rt;
    int                      pc;
    int                      steps;
    logic                    done;
    retireT                  rec;
    for (int i = 0; i < `CPU_NREGS; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < `CPU_DMEM_DEPTH; i++) begin
      mem[i] = '0;
    end
    expQ.delete();
    expErr = 1'b0;
    pc = 0;
    steps = 0;
    done = 1'b0;
    while (!done && steps < `CPU_IMEM_DEPTH) begin
      instr = prog[pc];
      op = instr[15:11];
      rd = instr[10:8];
      rs = instr[7:5];
      rt = instr[4:2];
      imm = {{11{instr[4]}}, instr[4:0]};
      off = {{8{instr[7]}}, instr[7:0]};
      a = regs[rs];
      b = regs[rt];
      addr = (a + imm) % `CPU_DMEM_DEPTH;
      rec = '0;
      rec.pc = 16'(pc);
      pc = pc + 1;
      case (op)
        opNop: begin
        end
        opAdd, opSub, opAnd, opXor, opAddi, opLd: begin
          rec.regWrite = 1'b1;
          rec.dest = rd;
          case (op)
            opAdd: rec.data = a + b;
            opSub: rec.data = a - b;
            opAnd: rec.data = a & b;
            opXor: rec.data = a ^ b;
            opAddi: rec.data = a + imm;
            default: rec.data = mem[addr];
          endcase
          regs[rd] = rec.data;
        end
        opSt: begin
          rec.store = 1'b1;
          rec.storeAddr = addr;
          rec.storeData = regs[rd];
          mem[addr] = regs[rd];
        end
        opBeqz: begin
          if (regs[rd] == '0) pc = pc + $signed(off);
        end
        opHalt: begin
          done = 1'b1;
        end
        // Illegal opcode ends the program with an error
        default: begin
          done = 1'b1;
          expErr = 1'b1;
        end
      endcase
      expQ.push_back(rec);
      steps++;
    end
    modelCount = expQ.size();
  endtask

  // Fields that carry no meaning for the instruction are skipped
  function automatic logic sameRecord(input retireT expRec, input retireT got);
    logic ok;
    ok = (expRec.pc === got.pc) && (expRec.regWrite === got.regWrite) &&
         (expRec.store === got.store);
    if (expRec.regWrite) begin
      ok = ok && (expRec.dest === got.dest) && (expRec.data === got.data);
    end
    if (expRec.store) begin
      ok = ok && (expRec.storeAddr === got.storeAddr) && (expRec.storeData === got.storeData);
    end
    return ok;
  endfunction

  // Load port is live only in reset, then five idle reset cycles
  task automatic resetAndLoad();
    @(posedge clk);
    #1;
    rstN = 1'b0;
    for (int i = 0; i < progLen; i++) begin
      progWe = 1'b1;
      progAddr = i[`CPU_IMEM_AW-1:0];
      progData = prog[i];
      @(posedge clk);
      #1;
    end
    progWe = 1'b0;
    repeat (resetCycles) begin
      @(posedge clk);
      #1;
    end
    retireCount = 0;
    rstN = 1'b1;
  endtask

  task automatic doRun(input int mode);
    genProgram(mode);
    runModel();
    resetAndLoad();
    while (!halted) @(negedge clk);
    // Make sure nothing trails the HALT
    repeat (3) @(negedge clk);
    checkCount += 3;
    assert (expQ.size() == 0) else begin
      errCount++;
      $display("ERR %0t: run %0d halted with %0d records not retired", $time, mode,
               expQ.size());
    end
    assert (retireCount == modelCount) else begin
      errCount++;
      $display("ERR %0t: run %0d retired %0d instructions, model %0d", $time, mode,
               retireCount, modelCount);
    end
    assert (err === expErr) else begin
      errCount++;
      $display("ERR %0t: run %0d err is %b, model %b", $time, mode, err, expErr);
    end
  endtask

  // Sampled at the falling edge, away from register updates
  always @(negedge clk) begin : retireMonitor
    retireT expRec;
    if (rstN && retireValid) begin
      retireCount++;
      checkCount++;
      assert (expQ.size() > 0) else begin
        errCount++;
        $display("ERR %0t: retire at pc %0d with no record expected", $time, retire.pc);
      end
      if (expQ.size() > 0) begin
        expRec = expQ.pop_front();
        assert (sameRecord(expRec, retire)) else begin
          errCount++;
          $display("ERR %0t: retire mismatch at pc %0d", $time, expRec.pc);
          $display("  exp pc %0d wr %b rd %0d data %h st %b addr %h sdata %h",
                   expRec.pc, expRec.regWrite, expRec.dest, expRec.data,
                   expRec.store, expRec.storeAddr, expRec.storeData);
          $display("  got pc %0d wr %b rd %0d data %h st %b addr %h sdata %h",
                   retire.pc, retire.regWrite, retire.dest, retire.data,
                   retire.store, retire.storeAddr, retire.storeData);
        end
      end
    end
  end

  initial begin
    #(watchdogNs);
    $display("Watchdog expired before the core halted on every run");
    $display("Something failed");
    $finish;
  end

  initial begin
    rstN = 1'b0;
    progWe = 1'b0;
    progAddr = '0;
    progData = '0;
    errCount = 0;
    svaFails = 0;
    checkCount = 0;
    retireCount = 0;
    modelCount = 0;
    expErr = 1'b0;
    // Every run starts with a fresh reset
    for (int r = 0; r < numRuns; r++) begin
      doRun(r);
    end
    // Failed pipeline properties from the bound checker
    svaFails = u_dut.sva.failCount;
    $display("Runs %0d, checks %0d, errors %0d, assertion failures %0d", numRuns,
             checkCount, errCount, svaFails);
    if (errCount == 0 && svaFails == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+design
design/isaPkg.sv
design/pipePkg.sv
design/pipeStage.sv
design/fetchUnit.sv
design/decodeUnit.sv
design/hazardUnit.sv
design/executeUnit.sv
design/memoryUnit.sv
design/proc.sv
test/proc_sva.sv
test/procTb.sv
